// File: cpuGlue.f
verilog/cpuGluePkg.sv
verilog/addressDecode.sv
verilog/transferAck.sv
verilog/ciaClock.sv
verilog/tickGen.sv
verilog/cpuGlue.sv
tb/cpuGlue_assert.sv
tb/cpuGlueTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the cpuGlue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpuGlueTb \
    -f cpuGlue.f -o simv
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

out=$(./obj_dir/simv 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q -F "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

// File: tb/cpuGlueTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuGlueTb;
    import cpuGluePkg::*;

    // Small divider values keep the run short
    localparam int ROM_WAIT    = 2;
    localparam int CIA_DIV     = 8;
    localparam int TICK60_HALF = 5;
    localparam int TICK50_HALF = 6;
    localparam int NUM_TXN     = 200;
    localparam int CYCLE_LIMIT = 300 * NUM_TXN + 500;

    logic        CLK40;
    logic        nRESET;
    logic        nTs;
    logic [1:0]  tt;
    logic        rnw;
    logic        ovl;
    logic        nLben;
    logic [31:12] addr;
    logic        nTaExt;
    wire         nTa;
    wire         taEn;
    wire         nTci;
    wire         nTbi;
    wire         nRomEn;
    wire         nBufEn;
    wire         nCiaCs0;
    wire         nCiaCs1;
    wire         nRamSpace;
    wire         nRegSpace;
    wire         ciaClk;
    wire         tick60;
    wire         tick50;

    // Select group, MSB first: nRomEn, nCiaCs0, nCiaCs1, nRamSpace, nRegSpace, nBufEn
    logic [5:0]  selVec;
    logic [31:0] lcgState;
    int          cycleCount = 0;

    assign selVec = {nRomEn, nCiaCs0, nCiaCs1, nRamSpace, nRegSpace, nBufEn};

    cpuGlue #(
        .ROM_WAIT    (ROM_WAIT),
        .CIA_DIV     (CIA_DIV),
        .TICK60_HALF (TICK60_HALF),
        .TICK50_HALF (TICK50_HALF)
    ) dut (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .nTs       (nTs),
        .tt        (tt),
        .rnw       (rnw),
        .ovl       (ovl),
        .nLben     (nLben),
        .addr      (addr),
        .nTaExt    (nTaExt),
        .nTa       (nTa),
        .taEn      (taEn),
        .nTci      (nTci),
        .nTbi      (nTbi),
        .nRomEn    (nRomEn),
        .nBufEn    (nBufEn),
        .nCiaCs0   (nCiaCs0),
        .nCiaCs1   (nCiaCs1),
        .nRamSpace (nRamSpace),
        .nRegSpace (nRegSpace),
        .ciaClk    (ciaClk),
        .tick60    (tick60),
        .tick50    (tick50)
    );

    // 100 ns clock
    always #50 CLK40 = ~CLK40;

    ////////////////////
    // Helpers
    ////////////////////

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at first error");
    endtask

    // Global watchdog
    always @(posedge CLK40) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            failRun("Timeout: the run did not finish within the cycle limit");
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic checkBit(input string name, input logic expV, input logic actV);
        if (actV !== expV) begin
            failRun($sformatf("MISMATCH %s: expected %b, actual %b", name, expV, actV));
        end
    endtask

    task automatic checkRegionSel(input string name, input regionT expRegion,
                                  input regionT actRegion, input logic [5:0] expSel,
                                  input logic [5:0] actSel);
        if (actRegion !== expRegion) begin
            failRun($sformatf("MISMATCH %s region: expected %s, actual %s",
                              name, expRegion.name(), actRegion.name()));
        end
        if (actSel !== expSel) begin
            failRun($sformatf("MISMATCH %s selects: expected %b, actual %b",
                              name, expSel, actSel));
        end
    endtask

    task automatic checkLatency(input string name, input int expV, input int actV);
        if (actV != expV) begin
            failRun($sformatf("MISMATCH %s: expected %0d, actual %0d", name, expV, actV));
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Decode rules in priority order
    function automatic regionT modelRegion(input logic [31:12] a, input logic [1:0] t,
                                           input logic o);
        if (t == 2'd3) return REGION_AUTOVEC;
        if (a[31:24] != 8'h00) return REGION_NONE;
        if (a[23:19] == 5'h1F) return REGION_ROM;
        // Overlay window, first 512 KB
        if (o && (a[23:19] == 5'h00)) return REGION_ROM;
        if (a[23:16] == 8'hBF) return REGION_CIA;
        if (a[23:12] == 12'hDFF) return REGION_CHIPREG;
        if (a[23:16] <= 8'h1F) return REGION_CHIPRAM;
        return REGION_NONE;
    endfunction

    function automatic logic [5:0] modelSel(input regionT r, input logic [31:12] a,
                                            input logic lben);
        logic [5:0] s;
        s = 6'b111111;
        case (r)
            REGION_ROM: s[5] = 1'b0;
            REGION_CIA: begin
                s[4] = a[12];
                s[3] = a[13];
            end
            REGION_CHIPRAM: begin
                s[2] = 1'b0;
                s[0] = lben;
            end
            REGION_CHIPREG: begin
                s[1] = 1'b0;
                s[0] = lben;
            end
            default: s = 6'b111111;
        endcase
        return s;
    endfunction

    // Address from the region list, random low bits
    function automatic logic [31:12] pickAddr(input logic [2:0] kind, input logic [31:0] rnd);
        logic [31:12] a;
        a = rnd[31:12];
        case (kind)
            3'd0, 3'd1: a[31:19] = 13'h001F;
            3'd2: a[31:16] = 16'h00BF;
            3'd3: a[31:12] = 20'h00DFF;
            // Chip RAM, overlay may turn it into ROM
            3'd4, 3'd5: a[31:21] = 11'd0;
            3'd6: a[31:24] = 8'h00;
            default: a[31:24] = a[31:24] | 8'h01;
        endcase
        return a;
    endfunction

    ////////////////////
    // One bus cycle
    ////////////////////

    // Called on a falling edge, returns on the falling edge after the cycle closes
    task automatic runTransaction(input int n);
        logic [31:0]  r;
        logic [31:0]  r2;
        logic [31:12] a;
        regionT       expRegion;
        logic [5:0]   expSel;
        string        name;
        int           i;
        int           expLat;
        int           actLat;
        int           extDelay;
        logic         prevClk;
        logic         acked;
        r  = nextRand();
        r2 = nextRand();
        a  = pickAddr(r[18:16], r2);
        nTs    = 1'b0;
        addr   = a;
        tt     = (r[23:21] == 3'd0) ? 2'd3 : {1'b0, r[20]};
        ovl    = r[25];
        nLben  = r[26];
        rnw    = r[27];
        expRegion = modelRegion(a, tt, ovl);
        expSel    = modelSel(expRegion, a, nLben);
        name      = $sformatf("txn %0d %s addr %h", n, expRegion.name(), a);
        @(negedge CLK40);
        nTs = 1'b1;
        i = 1;
        if ((expRegion == REGION_ROM) || (expRegion == REGION_AUTOVEC) ||
            (expRegion == REGION_CIA)) begin
            // ROM ack comes after ROM_WAIT waits that follow the first active cycle
            expLat  = (expRegion == REGION_CIA) ? 0 : ROM_WAIT + 2;
            prevClk = 1'b0;
            acked   = 1'b0;
            actLat  = 0;
            while (!acked) begin
                checkRegionSel(name, expRegion, dut.uDecode.region, expSel, selVec);
                // CIA ack follows the first falling ciaClk seen in the cycle
                if ((expRegion == REGION_CIA) && (expLat == 0) && (i >= 2) &&
                    prevClk && !ciaClk) begin
                    expLat = i;
                end
                if (!nTa) begin
                    acked  = 1'b1;
                    actLat = i;
                end else begin
                    checkBit({name, " taEn idle"}, 1'b0, taEn);
                    if (i > 4 * CIA_DIV) begin
                        failRun({"Bus cycle was never acknowledged: ", name});
                    end
                    prevClk = ciaClk;
                    @(negedge CLK40);
                    i++;
                end
            end
            checkLatency({name, " ack latency"}, expLat, actLat);
            checkBit({name, " taEn"}, 1'b1, taEn);
            checkBit({name, " nTbi"}, 1'b0, nTbi);
            checkBit({name, " nTci"}, (expRegion == REGION_CIA) ? 1'b0 : 1'b1, nTci);
            @(negedge CLK40);
        end else begin
            // Another agent ends the cycle
            extDelay = 1 + int'(r2[30:28]);
            while (i <= extDelay) begin
                checkRegionSel(name, expRegion, dut.uDecode.region, expSel, selVec);
                checkBit({name, " nTa held off"}, 1'b1, nTa);
                if (i == extDelay) begin
                    nTaExt = 1'b0;
                end
                @(negedge CLK40);
                i++;
            end
            nTaExt = 1'b1;
        end
        // Cycle closed, single ack pulse
        checkBit({name, " nTa after ack"}, 1'b1, nTa);
        checkBit({name, " selects released"}, 1'b1, &selVec);
    endtask

    // Interval between toggles after the first edge
    task automatic checkTicks();
        logic prev60;
        logic prev50;
        int   last60;
        int   last50;
        int   edges60;
        int   edges50;
        int   k;
        prev60  = tick60;
        prev50  = tick50;
        last60  = -1;
        last50  = -1;
        edges60 = 0;
        edges50 = 0;
        for (k = 1; k <= 200; k++) begin
            @(negedge CLK40);
            if (tick60 !== prev60) begin
                if (last60 >= 0) begin
                    checkLatency("tick60 half period", TICK60_HALF, k - last60);
                end
                last60 = k;
                edges60++;
            end
            if (tick50 !== prev50) begin
                if (last50 >= 0) begin
                    checkLatency("tick50 half period", TICK50_HALF, k - last50);
                end
                last50 = k;
                edges50++;
            end
            prev60 = tick60;
            prev50 = tick50;
        end
        if ((edges60 < 10) || (edges50 < 10)) begin
            failRun("A tick output stopped toggling");
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        CLK40    = 1'b0;
        nRESET   = 1'b0;
        nTs      = 1'b1;
        tt       = 2'd0;
        rnw      = 1'b1;
        ovl      = 1'b0;
        nLben    = 1'b1;
        addr     = '0;
        nTaExt   = 1'b1;
        lcgState = 32'hf317;
        repeat (3) @(negedge CLK40);
        // Inactive levels while still in reset
        checkBit("reset nTa", 1'b1, nTa);
        checkBit("reset taEn", 1'b0, taEn);
        checkBit("reset nTci", 1'b1, nTci);
        checkBit("reset nTbi", 1'b1, nTbi);
        checkBit("reset selects", 1'b1, &selVec);
        checkBit("reset ciaClk", 1'b0, ciaClk);
        checkBit("reset tick60", 1'b0, tick60);
        checkBit("reset tick50", 1'b0, tick50);
        nRESET = 1'b1;
        for (int n = 0; n < NUM_TXN; n++) begin
            runTransaction(n);
        end
        checkTicks();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/cpuGlue_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpuGlue_assert (
    input wire CLK40,
    input wire nRESET,
    input wire nTa,
    input wire taEn,
    input wire nTaExt
);

    ////////////////////
    // Ack protocol
    ////////////////////

    // Single cycle acknowledge
    ackPulse: assert property (@(posedge CLK40) disable iff (!nRESET) !nTa |=> nTa)
        else $error("nTa low for two consecutive cycles");

    // Pin driven while acknowledging
    ackDriven: assert property (@(posedge CLK40) disable iff (!nRESET) !nTa |-> taEn)
        else $error("nTa low without taEn");

    // Never two agents on the same cycle
    ackClash: assert property (@(posedge CLK40) disable iff (!nRESET) !(!nTa && !nTaExt))
        else $error("nTa and nTaExt low together");

endmodule

bind transferAck cpuGlue_assert uAckAssert (
    .CLK40  (CLK40),
    .nRESET (nRESET),
    .nTa    (nTa),
    .taEn   (taEn),
    .nTaExt (nTaExt)
);

`default_nettype wire

// File: verilog/addressDecode.sv
`timescale 1ns/1ps
`default_nettype none

module addressDecode (
    input  wire                CLK40,
    input  wire                nRESET,
    input  wire                nTs,
    input  wire  [1:0]         tt,
    input  wire                ovl,
    input  wire                nLben,
    input  wire  [31:12]       addr,
    input  wire                cycleDone,
    output cpuGluePkg::regionT region,
    output logic               cycleActive,
    output logic               nRomEn,
    output logic               nCiaCs0,
    output logic               nCiaCs1,
    output logic               nRamSpace,
    output logic               nRegSpace,
    output logic               nBufEn
);
    import cpuGluePkg::*;

    // Captured cycle attributes
    logic [31:12] addrQ;
    logic [1:0]   ttQ;
    logic         ovlQ;
    logic         nLbenQ;

    // Decode terms
    logic topZero;
    logic romRange;
    logic lowOverlay;

    ////////////////////
    // Cycle latch
    ////////////////////

    // Open on sampled nTs, close on the edge after the acknowledge
    always_ff @(posedge CLK40) begin
        if (!nRESET) begin
            cycleActive <= 1'b0;
        end else if (cycleActive) begin
            if (cycleDone) begin
                cycleActive <= 1'b0;
            end
        end else if (!nTs) begin
            cycleActive <= 1'b1;
        end
    end

    // nTs inside an open cycle is ignored
    always_ff @(posedge CLK40) begin
        if (!cycleActive && !nTs) begin
            addrQ  <= addr;
            ttQ    <= tt;
            ovlQ   <= ovl;
            nLbenQ <= nLben;
        end
    end

    ////////////////////
    // Region decode
    ////////////////////

    // Only the low 16 MB is mapped
    assign topZero    = (addrQ[31:24] == 8'h00);
    assign romRange   = (addrQ[23:19] == ROM_BASE_HI[7:3]);
    // Overlay puts ROM over the first 512 KB of chip RAM
    assign lowOverlay = ovlQ && (addrQ[23:19] == 5'd0);

    always_comb begin
        if (ttQ == TT_AUTOVEC) begin
            region = REGION_AUTOVEC;
        end else if (!topZero) begin
            region = REGION_NONE;
        end else if (romRange || lowOverlay) begin
            region = REGION_ROM;
        end else if (addrQ[23:16] == CIA_PAGE) begin
            region = REGION_CIA;
        end else if (addrQ[23:12] == CHIPREG_PAGE) begin
            region = REGION_CHIPREG;
        end else if (addrQ[23:16] <= CHIPRAM_TOP) begin
            // Overlay case already taken by ROM above
            region = REGION_CHIPRAM;
        end else begin
            region = REGION_NONE;
        end
    end

    ////////////////////
    // Selects
    ////////////////////

    assign nRomEn    = !(cycleActive && (region == REGION_ROM));
    // A12 low picks CIA 0, A13 low picks CIA 1
    assign nCiaCs0   = !(cycleActive && (region == REGION_CIA) && !addrQ[12]);
    assign nCiaCs1   = !(cycleActive && (region == REGION_CIA) && !addrQ[13]);
    assign nRamSpace = !(cycleActive && (region == REGION_CHIPRAM));
    assign nRegSpace = !(cycleActive && (region == REGION_CHIPREG));

    // Data buffers only for chip bus cycles on the low lanes
    assign nBufEn = !(cycleActive && !nLbenQ &&
                      ((region == REGION_CHIPRAM) || (region == REGION_CHIPREG)));

endmodule

`default_nettype wire

// File: verilog/ciaClock.sv
`timescale 1ns/1ps
`default_nettype none

module ciaClock #(
    parameter int CIA_DIV = 56
) (
    input  wire  CLK40,
    input  wire  nRESET,
    output logic ciaClk,
    output logic ciaStrobe
);

    localparam int CNT_W = (CIA_DIV > 2) ? $clog2(CIA_DIV) : 1;
    localparam int HALF  = CIA_DIV / 2;

    // Position within one CIA clock period
    logic [CNT_W-1:0] divCnt;

    ////////////////////
    // Divider
    ////////////////////

    // Low for the first half, high for the second
    always_ff @(posedge CLK40) begin
        if (!nRESET) begin
            divCnt <= '0;
            ciaClk <= 1'b0;
        end else if (divCnt == CNT_W'(CIA_DIV - 1)) begin
            divCnt <= '0;
            ciaClk <= 1'b0;
        end else begin
            divCnt <= divCnt + 1'b1;
            if (divCnt == CNT_W'(HALF - 1)) begin
                ciaClk <= 1'b1;
            end
        end
    end

    // Last high cycle, falling edge follows
    assign ciaStrobe = (divCnt == CNT_W'(CIA_DIV - 1));

endmodule

`default_nettype wire

// File: verilog/cpuGlue.sv
`timescale 1ns/1ps
`default_nettype none

module cpuGlue #(
    parameter int ROM_WAIT    = 3,
    parameter int CIA_DIV     = 56,
    parameter int TICK60_HALF = 333333,
    parameter int TICK50_HALF = 400000
) (
    input  wire          CLK40,
    input  wire          nRESET,
    input  wire          nTs,
    input  wire  [1:0]   tt,
    input  wire          rnw,
    input  wire          ovl,
    input  wire          nLben,
    input  wire  [31:12] addr,
    input  wire          nTaExt,
    output wire          nTa,
    output wire          taEn,
    output wire          nTci,
    output wire          nTbi,
    output wire          nRomEn,
    output wire          nBufEn,
    output wire          nCiaCs0,
    output wire          nCiaCs1,
    output wire          nRamSpace,
    output wire          nRegSpace,
    output wire          ciaClk,
    output wire          tick60,
    output wire          tick50
);
    import cpuGluePkg::*;

    // Decode to acknowledge
    regionT region;
    logic   cycleActive;
    // Acknowledge back to decode
    logic   cycleDone;
    // End of CIA clock high phase
    logic   ciaStrobe;

    ////////////////////
    // Address decode
    ////////////////////

    addressDecode uDecode (
        .CLK40       (CLK40),
        .nRESET      (nRESET),
        .nTs         (nTs),
        .tt          (tt),
        .ovl         (ovl),
        .nLben       (nLben),
        .addr        (addr),
        .cycleDone   (cycleDone),
        .region      (region),
        .cycleActive (cycleActive),
        .nRomEn      (nRomEn),
        .nCiaCs0     (nCiaCs0),
        .nCiaCs1     (nCiaCs1),
        .nRamSpace   (nRamSpace),
        .nRegSpace   (nRegSpace),
        .nBufEn      (nBufEn)
    );

    ////////////////////
    // Transfer ack
    ////////////////////

    transferAck #(
        .ROM_WAIT (ROM_WAIT)
    ) uAck (
        .CLK40       (CLK40),
        .nRESET      (nRESET),
        .region      (region),
        .cycleActive (cycleActive),
        .ciaStrobe   (ciaStrobe),
        .nTaExt      (nTaExt),
        .nTa         (nTa),
        .taEn        (taEn),
        .nTci        (nTci),
        .nTbi        (nTbi),
        .cycleDone   (cycleDone)
    );

    ////////////////////
    // Clocks and ticks
    ////////////////////

    ciaClock #(
        .CIA_DIV (CIA_DIV)
    ) uCiaClock (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .ciaClk    (ciaClk),
        .ciaStrobe (ciaStrobe)
    );

    tickGen #(
        .TICK60_HALF (TICK60_HALF),
        .TICK50_HALF (TICK50_HALF)
    ) uTick (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .tick60 (tick60),
        .tick50 (tick50)
    );

endmodule

`default_nettype wire

// File: verilog/cpuGluePkg.sv
`default_nettype none

package cpuGluePkg;

    ////////////////////
    // Cycle regions
    ////////////////////

    // Region of the open bus cycle, REGION_NONE for unmapped space
    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_ROM,
        REGION_CIA,
        REGION_CHIPRAM,
        REGION_CHIPREG,
        REGION_AUTOVEC
    } regionT;

    ////////////////////
    // Acknowledge FSM
    ////////////////////

    typedef enum logic [2:0] {
        ACK_IDLE,
        ACK_ROMWAIT,
        ACK_CIAWAIT,
        ACK_DRIVE,
        ACK_EXTWAIT
    } ackStateT;

    // Transfer type of an interrupt acknowledge
    localparam logic [1:0] TT_AUTOVEC = 2'd3;

    ////////////////////
    // Address map
    ////////////////////

    // ROM at 0xF80000-0xFFFFFF, only bits 23:19 are compared
    localparam logic [7:0] ROM_BASE_HI = 8'hF8;
    // CIA page, bits 23:16
    localparam logic [7:0] CIA_PAGE = 8'hBF;
    // Chip register page, bits 23:12
    localparam logic [11:0] CHIPREG_PAGE = 12'hDFF;
    // Last chip RAM page, bits 23:16
    localparam logic [7:0] CHIPRAM_TOP = 8'h1F;

endpackage

`default_nettype wire

// File: verilog/tickGen.sv
`timescale 1ns/1ps
`default_nettype none

module tickGen #(
    parameter int TICK60_HALF = 333333,
    parameter int TICK50_HALF = 400000
) (
    input  wire  CLK40,
    input  wire  nRESET,
    output logic tick60,
    output logic tick50
);

    // Sized for the longer half period
    localparam int MAX_HALF = (TICK60_HALF > TICK50_HALF) ? TICK60_HALF : TICK50_HALF;
    localparam int CNT_W    = (MAX_HALF > 2) ? $clog2(MAX_HALF) : 1;

    ////////////////////
    // Tick dividers
    ////////////////////

    // Index 0 is 60 Hz, index 1 is 50 Hz
    for (genvar i = 0; i < 2; i++) begin : gTick
        localparam int HALF_LEN = (i == 0) ? TICK60_HALF : TICK50_HALF;

        logic [CNT_W-1:0] halfCnt;
        logic             tickQ;

        // Toggle at the end of each half period
        always_ff @(posedge CLK40) begin
            if (!nRESET) begin
                halfCnt <= '0;
                tickQ   <= 1'b0;
            end else if (halfCnt == CNT_W'(HALF_LEN - 1)) begin
                halfCnt <= '0;
                tickQ   <= !tickQ;
            end else begin
                halfCnt <= halfCnt + 1'b1;
            end
        end
    end

    assign tick60 = gTick[0].tickQ;
    assign tick50 = gTick[1].tickQ;

endmodule

`default_nettype wire

// File: verilog/transferAck.sv
`timescale 1ns/1ps
`default_nettype none

module transferAck #(
    parameter int ROM_WAIT = 3
) (
    input  wire                CLK40,
    input  wire                nRESET,
    input  wire cpuGluePkg::regionT region,
    input  wire                cycleActive,
    input  wire                ciaStrobe,
    input  wire                nTaExt,
    output logic               nTa,
    output logic               taEn,
    output logic               nTci,
    output logic               nTbi,
    output logic               cycleDone
);
    import cpuGluePkg::*;

    // Waits follow the idle cycle that first sees the cycle open
    localparam int WAIT_W = (ROM_WAIT > 2) ? $clog2(ROM_WAIT) : 1;
    localparam logic [WAIT_W-1:0] WAIT_LOAD = (ROM_WAIT > 1) ? WAIT_W'(ROM_WAIT - 1) : '0;

    ackStateT          state;
    ackStateT          stateNext;
    logic [WAIT_W-1:0] waitCnt;
    logic              driveAck;

    ////////////////////
    // State register
    ////////////////////

    always_ff @(posedge CLK40) begin
        if (!nRESET) begin
            state <= ACK_IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // Preloaded in idle, counts down in ROM wait
    always_ff @(posedge CLK40) begin
        if (state == ACK_IDLE) begin
            waitCnt <= WAIT_LOAD;
        end else if ((state == ACK_ROMWAIT) && (waitCnt != '0)) begin
            waitCnt <= waitCnt - 1'b1;
        end
    end

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            ACK_IDLE: begin
                // Cycle already ended by another agent stays here
                if (cycleActive && nTaExt) begin
                    case (region)
                        REGION_ROM, REGION_AUTOVEC: begin
                            if (ROM_WAIT > 0) begin
                                stateNext = ACK_ROMWAIT;
                            end else begin
                                stateNext = ACK_DRIVE;
                            end
                        end
                        REGION_CIA: begin
                            // Strobe already here, ack next cycle
                            if (ciaStrobe) begin
                                stateNext = ACK_DRIVE;
                            end else begin
                                stateNext = ACK_CIAWAIT;
                            end
                        end
                        // Chip bus and unmapped cycles end on nTaExt
                        default: stateNext = ACK_EXTWAIT;
                    endcase
                end
            end
            ACK_ROMWAIT: begin
                if (!nTaExt) begin
                    stateNext = ACK_IDLE;
                end else if (waitCnt == '0) begin
                    stateNext = ACK_DRIVE;
                end
            end
            ACK_CIAWAIT: begin
                if (!nTaExt) begin
                    stateNext = ACK_IDLE;
                end else if (ciaStrobe) begin
                    stateNext = ACK_DRIVE;
                end
            end
            // Single cycle acknowledge
            ACK_DRIVE: stateNext = ACK_IDLE;
            ACK_EXTWAIT: begin
                if (!nTaExt) begin
                    stateNext = ACK_IDLE;
                end
            end
            default: stateNext = ACK_IDLE;
        endcase
    end

    ////////////////////
    // Bus outputs
    ////////////////////

    assign driveAck = (state == ACK_DRIVE);
    assign nTa      = !driveAck;
    assign taEn     = driveAck;
    // No bursts from any region here
    assign nTbi     = !driveAck;
    // CIA registers are never cached
    assign nTci     = !(driveAck && (region == REGION_CIA));

    // Either acknowledge closes the cycle
    assign cycleDone = cycleActive && (driveAck || !nTaExt);

endmodule

`default_nettype wire
